/* fcs_macros.svh */
// FCS macros: CRC-32 constants and frame length limits shared by the FCS unit
`ifndef FCS_MACROS_SVH
`define FCS_MACROS_SVH

// ----------------------------------------
// CRC-32 constants
// ----------------------------------------

// Generator polynomial, normal form
`define CRC_POLYNOMIAL 32'h04C1_1DB7

// Register load value at frame start
`define CRC_PRELOAD 32'hFFFF_FFFF

// Register value once a good frame and its FCS have gone through
`define CRC_RESIDUE 32'hC704_DD7B

// ----------------------------------------
// Frame lengths
// ----------------------------------------

// Bytes in the appended FCS
`define FCS_BYTES 4

// Shortest legal receive frame, one data byte plus the FCS
`define MIN_FRAME_BYTES 5

`endif

/* fcs_pkg.sv */
// FCS package: data, CRC, length, beat and status types plus the framer FSM states
package fcs_pkg;

  // ----------------------------------------
  // Plain vector types
  // ----------------------------------------

  // One data byte on either path
  typedef logic [7:0] byte_t;

  // CRC register contents
  typedef logic [31:0] crc_t;

  // Byte count of a frame
  typedef logic [15:0] frame_len_t;

  // ----------------------------------------
  // Bundles
  // ----------------------------------------

  // Byte stream beat, single-cycle strobe, no back-pressure
  typedef struct packed {
    logic  valid;
    logic  sof;
    logic  eof;
    byte_t data;
  } beat_t;

  // Receive verdict, done pulses once per frame
  typedef struct packed {
    logic       done;
    logic       fcs_ok;
    frame_len_t length;
  } rx_status_t;

  // Transmit framer FSM
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_DATA = 2'd1,
    TX_FCS  = 2'd2
  } tx_state_t;

endpackage

/* crc_gen_chk.sv */
// CRC-32 engine: byte-serial generator and checker, LSB first, with FCS drain
`timescale 1ns/1ps
`include "fcs_macros.svh"

module crc_gen_chk (
  input  logic           clk,
  input  logic           reset_N,
  // Load preload, wins over everything else
  input  logic           start,
  // Qualifies every operation
  input  logic           enable,
  // Ends accumulation, FCS bytes follow on the next enables
  input  logic           drain,
  input  fcs_pkg::byte_t d_in,
  output fcs_pkg::byte_t d_out,
  // Residue match, registered on enable
  output logic           crc_ok
);
  import fcs_pkg::*;

  crc_t       crc_q;
  crc_t       crc_next;
  logic       accumulating;
  logic       draining;
  logic [1:0] drain_cnt;
  logic       last_drain;
  logic       crc_upd;
  byte_t      top_inv;

  // ----------------------------------------
  // Next register value
  // ----------------------------------------

  // Eight single-bit steps per byte, bit 0 first
  // With accumulating low the feedback is masked, so the register
  // just moves up one byte, which is how the drain walks through it
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < 8; i++) begin
      crc_next = {crc_next[30:0], 1'b0} ^
                 (`CRC_POLYNOMIAL & {32{(d_in[i] ^ crc_next[31]) & accumulating}});
    end
  end

  // Register moves while accumulating or draining
  assign crc_upd = enable & (accumulating | draining);

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      crc_q <= '0;
    end else if (start) begin
      crc_q <= `CRC_PRELOAD;
    end else if (crc_upd) begin
      crc_q <= crc_next;
    end
  end

  // ----------------------------------------
  // Mode flags
  // ----------------------------------------

  // Set by start, cleared by drain
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      accumulating <= 1'b0;
    end else if (enable) begin
      accumulating <= start | (~drain & accumulating);
    end
  end

  // Counts the FCS bytes already sent
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      drain_cnt <= 2'd0;
    end else if (draining && enable) begin
      drain_cnt <= drain_cnt + 2'd1;
    end
  end

  assign last_drain = (drain_cnt == 2'(`FCS_BYTES - 1));

  // Held until the last FCS byte has gone out
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      draining <= 1'b0;
    end else if (enable) begin
      draining <= (accumulating & drain) | (draining & ~last_drain);
    end
  end

  // ----------------------------------------
  // Check and output
  // ----------------------------------------

  // Compare the value that includes the current byte
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      crc_ok <= 1'b0;
    end else if (enable) begin
      crc_ok <= (crc_next == `CRC_RESIDUE);
    end
  end

  // Final inversion on the top byte
  assign top_inv = ~crc_q[31:24];

  // Data passes through; while draining the top byte goes out
  // bit-reversed, which gives the reflected CRC LSB first
  always_comb begin
    d_out = d_in;
    if (draining) begin
      for (int j = 0; j < 8; j++) begin
        d_out[j] = top_inv[7 - j];
      end
    end
  end

endmodule

/* fcs_tx_framer.sv */
// Transmit framer: passes frame bytes through and appends the four CRC-32 FCS bytes
`timescale 1ns/1ps
`include "fcs_macros.svh"

module fcs_tx_framer (
  input  logic           clk,
  input  logic           reset_N,
  input  fcs_pkg::beat_t tx_in,
  output fcs_pkg::beat_t tx_out,
  // One cycle after a dropped beat
  output logic           tx_overrun
);
  import fcs_pkg::*;

  tx_state_t  state;
  tx_state_t  state_nxt;
  beat_t      beat_q;
  logic [1:0] fcs_cnt;
  logic       fcs_last;
  logic       last_byte;
  logic       accept;
  logic       drop;
  logic       crc_start;
  logic       crc_enable;
  logic       crc_drain;
  byte_t      crc_dout;

  // ----------------------------------------
  // Input acceptance
  // ----------------------------------------

  // Registered eof byte is on its way out this cycle
  assign last_byte = beat_q.valid & beat_q.eof;
  assign fcs_last  = (fcs_cnt == 2'(`FCS_BYTES - 1));

  // Idle wants sof, data takes anything up to eof, FCS takes nothing
  always_comb begin
    unique case (state)
      TX_IDLE: accept = tx_in.valid & tx_in.sof;
      TX_DATA: accept = tx_in.valid & ~last_byte;
      default: accept = 1'b0;
    endcase
    drop = tx_in.valid & ~accept;
  end

  // Beat held one cycle, valid only when taken
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      beat_q <= '0;
    end else begin
      beat_q       <= tx_in;
      beat_q.valid <= accept;
    end
  end

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      tx_overrun <= 1'b0;
    end else begin
      tx_overrun <= drop;
    end
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    unique case (state)
      TX_IDLE: if (accept) state_nxt = TX_DATA;
      TX_DATA: if (last_byte) state_nxt = TX_FCS;
      TX_FCS:  if (fcs_last) state_nxt = TX_IDLE;
      default: state_nxt = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      state <= TX_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // FCS byte index, own count kept beside the engine
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      fcs_cnt <= 2'd0;
    end else if (state == TX_FCS) begin
      fcs_cnt <= fcs_cnt + 2'd1;
    end else begin
      fcs_cnt <= 2'd0;
    end
  end

  // ----------------------------------------
  // CRC engine
  // ----------------------------------------

  // Start with sof, then one enable per registered byte and per FCS byte
  assign crc_start  = accept & (state == TX_IDLE);
  assign crc_enable = crc_start | beat_q.valid | (state == TX_FCS);
  assign crc_drain  = last_byte;

  crc_gen_chk crc0 (
    .clk     (clk),
    .reset_N (reset_N),
    .start   (crc_start),
    .enable  (crc_enable),
    .drain   (crc_drain),
    .d_in    (beat_q.data),
    .d_out   (crc_dout),
    .crc_ok  ()
  );

  // Data beats keep sof and lose eof; eof moves to the last FCS byte
  always_comb begin
    tx_out      = '0;
    tx_out.data = crc_dout;
    if (state == TX_FCS) begin
      tx_out.valid = 1'b1;
      tx_out.eof   = fcs_last;
    end else begin
      tx_out.valid = beat_q.valid;
      tx_out.sof   = beat_q.sof;
    end
  end

endmodule

/* fcs_rx_checker.sv */
// Receive checker: runs each frame with its FCS through the CRC engine and reports length and verdict
`timescale 1ns/1ps
`include "fcs_macros.svh"

module fcs_rx_checker (
  input  logic               clk,
  input  logic               reset_N,
  input  fcs_pkg::beat_t     rx_in,
  output fcs_pkg::rx_status_t rx_status
);
  import fcs_pkg::*;

  beat_t      beat_q;
  logic       in_frame;
  logic       take;
  logic       crc_start;
  logic       crc_enable;
  logic       crc_ok;
  logic       done_q;
  logic       len_ok;
  frame_len_t len_q;

  // ----------------------------------------
  // Frame tracking
  // ----------------------------------------

  // Beats outside a frame are ignored until the next sof
  assign take = rx_in.valid & (rx_in.sof | in_frame);

  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      in_frame <= 1'b0;
    end else if (take) begin
      in_frame <= ~rx_in.eof;
    end
  end

  // One-cycle hold so the engine sees the byte after its start
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      beat_q <= '0;
    end else begin
      beat_q       <= rx_in;
      beat_q.valid <= take;
    end
  end

  // Counts every beat, FCS included; sof restarts at one
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      len_q <= '0;
    end else if (beat_q.valid) begin
      len_q <= beat_q.sof ? frame_len_t'(1) : len_q + frame_len_t'(1);
    end
  end

  // ----------------------------------------
  // CRC engine in check mode
  // ----------------------------------------

  assign crc_start  = take & rx_in.sof;
  assign crc_enable = crc_start | beat_q.valid;

  // Never drained, the FCS bytes are simply accumulated
  crc_gen_chk crc0 (
    .clk     (clk),
    .reset_N (reset_N),
    .start   (crc_start),
    .enable  (crc_enable),
    .drain   (1'b0),
    .d_in    (beat_q.data),
    .d_out   (),
    .crc_ok  (crc_ok)
  );

  // ----------------------------------------
  // Status
  // ----------------------------------------

  // crc_ok and len_q settle together, one cycle after the eof byte
  always_ff @(posedge clk or negedge reset_N) begin
    if (!reset_N) begin
      done_q <= 1'b0;
    end else begin
      done_q <= beat_q.valid & beat_q.eof;
    end
  end

  // Too short to hold data plus FCS
  assign len_ok = (len_q >= frame_len_t'(`MIN_FRAME_BYTES));

  assign rx_status.done   = done_q;
  assign rx_status.fcs_ok = done_q & crc_ok & len_ok;
  assign rx_status.length = len_q;

endmodule

/* fcs_unit.sv */
// FCS unit top: transmit framer and receive checker side by side
`timescale 1ns/1ps

module fcs_unit (
  input  logic                clk,
  input  logic                reset_N,

  // ----------------------------------------
  // Transmit path
  // ----------------------------------------

  // Frame bytes from the MAC
  input  fcs_pkg::beat_t      tx_in,
  // Same bytes plus FCS, one cycle later
  output fcs_pkg::beat_t      tx_out,
  // Beat dropped for breaking the gap rule
  output logic                tx_overrun,

  // ----------------------------------------
  // Receive path
  // ----------------------------------------

  // Received frame with its FCS
  input  fcs_pkg::beat_t      rx_in,
  // Length and verdict, two cycles after eof
  output fcs_pkg::rx_status_t rx_status
);

  // Transmit side, own CRC engine inside
  fcs_tx_framer tx_framer0 (
    .clk        (clk),
    .reset_N    (reset_N),
    .tx_in      (tx_in),
    .tx_out     (tx_out),
    .tx_overrun (tx_overrun)
  );

  // Receive side, separate CRC engine so both paths run at once
  fcs_rx_checker rx_checker0 (
    .clk       (clk),
    .reset_N   (reset_N),
    .rx_in     (rx_in),
    .rx_status (rx_status)
  );

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source: 100 ns period, reset low for the first four cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset_N
);

  // Half period of 50 ns
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Four rising edges in reset, released on a falling edge
  initial begin
    reset_N = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_N = 1'b1;
  end

endmodule

/* tb_fcs_unit.sv */
// FCS unit testbench: CRC-32 reference model, framed stimulus on both paths and checks
`timescale 1ns/1ps
`include "fcs_macros.svh"

module tb_fcs_unit;
  import fcs_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic       clk;
  logic       reset_N;
  beat_t      tx_in;
  beat_t      tx_out;
  logic       tx_overrun;
  beat_t      rx_in;
  rx_status_t rx_status;

  // Expectations set with each driven beat, and their one-cycle history
  logic       pass_exp;
  logic       drop_exp;
  logic       pass_q;
  logic       drop_q;
  beat_t      tx_in_q;
  logic [1:0] rx_eof_q;

  beat_t      exp_tx[$];
  rx_status_t exp_rx[$];
  byte_t      tx_seen[$];
  beat_t      exp_beat;
  rx_status_t exp_stat;
  string      test_name;

  int tx_errors      = 0;
  int rx_errors      = 0;
  int pass_errors    = 0;
  int overrun_errors = 0;
  int done_errors    = 0;
  int check_errors   = 0;
  int timeout_errors = 0;

  tb_clock_gen clk_gen0 (
    .clk     (clk),
    .reset_N (reset_N)
  );

  fcs_unit dut0 (
    .clk        (clk),
    .reset_N    (reset_N),
    .tx_in      (tx_in),
    .tx_out     (tx_out),
    .tx_overrun (tx_overrun),
    .rx_in      (rx_in),
    .rx_status  (rx_status)
  );

  // ----------------------------------------
  // Timing checks
  // ----------------------------------------

  always @(posedge clk) begin
    pass_q   <= pass_exp;
    drop_q   <= drop_exp;
    tx_in_q  <= tx_in;
    rx_eof_q <= {rx_eof_q[0], rx_in.valid & rx_in.eof};
  end

  // Accepted beat one cycle later, same data and sof, eof cleared
  assert property (@(posedge clk) disable iff (!reset_N)
      pass_q |-> (tx_out.valid && !tx_out.eof && tx_out.sof == tx_in_q.sof &&
                  tx_out.data == tx_in_q.data))
    else begin
      pass_errors++;
      $display("error %s tx_out expected data %h actual valid %b eof %b data %h", test_name,
               $sampled(tx_in_q.data), $sampled(tx_out.valid), $sampled(tx_out.eof),
               $sampled(tx_out.data));
    end

  // Overrun strobe exactly one cycle after a dropped beat, never otherwise
  assert property (@(posedge clk) disable iff (!reset_N) tx_overrun == drop_q)
    else begin
      overrun_errors++;
      $display("error %s tx_overrun expected %b actual %b", test_name,
               $sampled(drop_q), $sampled(tx_overrun));
    end

  // Status two cycles after the eof beat on rx_in
  assert property (@(posedge clk) disable iff (!reset_N) rx_status.done == rx_eof_q[1])
    else begin
      done_errors++;
      $display("error %s rx_status.done expected %b actual %b", test_name,
               $sampled(rx_eof_q[1]), $sampled(rx_status.done));
    end

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  always @(posedge clk) begin
    if (reset_N && tx_out.valid) begin
      tx_seen.push_back(tx_out.data);
      if (exp_tx.size() == 0) begin
        tx_errors++;
        $display("%s: beat %h came out on tx_out with none expected", test_name, tx_out);
      end else begin
        exp_beat = exp_tx.pop_front();
        assert (tx_out == exp_beat) else begin
          tx_errors++;
          $display("error %s tx_out expected %h actual %h", test_name, exp_beat, tx_out);
        end
      end
    end
    if (reset_N && rx_status.done) begin
      if (exp_rx.size() == 0) begin
        rx_errors++;
        $display("%s: rx_status reported with no frame expected", test_name);
      end else begin
        exp_stat = exp_rx.pop_front();
        assert (rx_status.fcs_ok == exp_stat.fcs_ok) else begin
          rx_errors++;
          $display("error %s fcs_ok expected %b actual %b", test_name,
                   exp_stat.fcs_ok, rx_status.fcs_ok);
        end
        assert (rx_status.length == exp_stat.length) else begin
          rx_errors++;
          $display("error %s length expected %0d actual %0d", test_name,
                   exp_stat.length, rx_status.length);
        end
      end
    end
  end

  // ----------------------------------------
  // Model and stimulus tasks
  // ----------------------------------------

  // Reflected CRC-32, LSB first, ones preload and final inversion
  task automatic crc_model(input byte_t bytes[$], output crc_t fcs);
    crc_t c;
    c = `CRC_PRELOAD;
    foreach (bytes[i]) begin
      c = c ^ crc_t'(bytes[i]);
      for (int b = 0; b < 8; b++) begin
        // Reflected form of the generator
        c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
      end
    end
    fcs = ~c;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One frame on tx_in; intrude puts a sof beat into the FCS append
  task automatic send_tx_frame(input byte_t bytes[$], input logic intrude);
    crc_t fcs;
    int   n;
    crc_model(bytes, fcs);
    tx_seen.delete();
    foreach (bytes[i]) begin
      exp_tx.push_back(beat_t'{valid: 1'b1, sof: (i == 0), eof: 1'b0, data: bytes[i]});
    end
    // FCS least significant byte first, eof on the last one
    for (int i = 0; i < `FCS_BYTES; i++) begin
      exp_tx.push_back(beat_t'{valid: 1'b1, sof: 1'b0, eof: (i == `FCS_BYTES - 1),
                               data: fcs[8*i +: 8]});
    end
    for (int i = 0; i < bytes.size(); i++) begin
      @(negedge clk);
      tx_in    = '{valid: 1'b1, sof: (i == 0), eof: (i == bytes.size() - 1), data: bytes[i]};
      pass_exp = 1'b1;
    end
    for (int g = 0; g < 3; g++) begin
      @(negedge clk);
      tx_in    = '0;
      pass_exp = 1'b0;
      // Third cycle after eof is the second FCS byte
      if (intrude && g == 2) begin
        tx_in    = '{valid: 1'b1, sof: 1'b1, eof: 1'b0, data: byte_t'($urandom())};
        drop_exp = 1'b1;
      end
    end
    @(negedge clk);
    tx_in    = '0;
    drop_exp = 1'b0;
    n = 0;
    while (exp_tx.size() != 0 && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (exp_tx.size() != 0) begin
      timeout_errors++;
      $display("%s: timed out with %0d tx beats still missing", test_name, exp_tx.size());
      exp_tx.delete();
    end
  endtask

  // One frame on rx_in, FCS bytes included in bytes
  task automatic send_rx_frame(input byte_t bytes[$], input logic fcs_good,
                               input frame_len_t exp_len);
    int n;
    exp_rx.push_back(rx_status_t'{done: 1'b1, fcs_ok: fcs_good, length: exp_len});
    for (int i = 0; i < bytes.size(); i++) begin
      @(negedge clk);
      rx_in = '{valid: 1'b1, sof: (i == 0), eof: (i == bytes.size() - 1), data: bytes[i]};
    end
    @(negedge clk);
    rx_in = '0;
    n = 0;
    while (exp_rx.size() != 0 && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (exp_rx.size() != 0) begin
      timeout_errors++;
      $display("%s: timed out waiting for rx_status", test_name);
      exp_rx.delete();
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int    n;
    int    len;
    int    pos;
    crc_t  fcs;
    byte_t frame[$];
    byte_t bad[$];
    void'($urandom(47));
    tx_in     = '0;
    rx_in     = '0;
    pass_exp  = 1'b0;
    drop_exp  = 1'b0;
    test_name = "reset";
    @(negedge clk);
    n = 0;
    while (!reset_N && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!reset_N) begin
      timeout_errors++;
      $display("reset never released");
    end

    // Quiet outputs before any frame
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (!tx_out.valid && !tx_overrun && !rx_status.done) else begin
        check_errors++;
        $display("error %s valid/overrun/done expected 000 actual %b%b%b", test_name,
                 tx_out.valid, tx_overrun, rx_status.done);
      end
    end

    // ASCII "123456789", FCS bytes 26 39 F4 CB
    test_name = "known_frame";
    for (int i = 0; i < 9; i++) begin
      frame.push_back(byte_t'(8'h31 + i));
    end
    crc_model(frame, fcs);
    assert (fcs == 32'hCBF4_3926) else begin
      check_errors++;
      $display("error %s model crc expected cbf43926 actual %h", test_name, fcs);
    end
    send_tx_frame(frame, 1'b0);
    send_rx_frame(tx_seen, 1'b1, frame_len_t'(9 + `FCS_BYTES));

    // Random lengths and gaps, each frame looped back into the checker
    test_name = "random_frames";
    for (int f = 0; f < 20; f++) begin
      frame.delete();
      len = $urandom_range(64, 1);
      for (int i = 0; i < len; i++) begin
        frame.push_back(byte_t'($urandom()));
      end
      send_tx_frame(frame, 1'b0);
      idle_cycles($urandom_range(7, 0));
      send_rx_frame(tx_seen, 1'b1, frame_len_t'(len + `FCS_BYTES));
      // Single bit flip anywhere in data or FCS
      if (f % 4 == 0) begin
        bad = tx_seen;
        pos = $urandom_range(8 * bad.size() - 1, 0);
        bad[pos / 8] = bad[pos / 8] ^ byte_t'(1 << (pos % 8));
        send_rx_frame(bad, 1'b0, frame_len_t'(len + `FCS_BYTES));
      end
    end

    // Below the minimum frame length
    test_name = "short_frame";
    frame.delete();
    for (int i = 0; i < 3; i++) begin
      frame.push_back(byte_t'($urandom()));
    end
    send_rx_frame(frame, 1'b0, frame_len_t'(3));

    // FCS of an empty payload, residue matches but one byte short
    frame.delete();
    crc_model(frame, fcs);
    for (int i = 0; i < `FCS_BYTES; i++) begin
      frame.push_back(fcs[8*i +: 8]);
    end
    send_rx_frame(frame, 1'b0, frame_len_t'(`FCS_BYTES));

    // New sof while the FCS goes out
    test_name = "overrun";
    frame.delete();
    len = $urandom_range(16, 1);
    for (int i = 0; i < len; i++) begin
      frame.push_back(byte_t'($urandom()));
    end
    send_tx_frame(frame, 1'b1);
    send_rx_frame(tx_seen, 1'b1, frame_len_t'(len + `FCS_BYTES));

    idle_cycles(4);
    $display("errors: tx %0d rx %0d pass %0d overrun %0d done %0d check %0d timeout %0d",
             tx_errors, rx_errors, pass_errors, overrun_errors, done_errors, check_errors,
             timeout_errors);
    if (tx_errors + rx_errors + pass_errors + overrun_errors + done_errors +
        check_errors + timeout_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* fcs_unit.f */
+incdir+.
fcs_pkg.sv
crc_gen_chk.sv
fcs_tx_framer.sv
fcs_rx_checker.sv
fcs_unit.sv
tb_clock_gen.sv
tb_fcs_unit.sv

/* Makefile */
VERILATOR = verilator
TOP       = tb_fcs_unit
FILELIST  = fcs_unit.f
FLAGS     = --binary --timing --assert -j 0
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output goes to the terminal and through grep, the status comes from grep
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
